/* common/wb_pkg.sv */
/*
 * Shared types and register map of the white-balance stage.
 * Gains are unsigned Q3.10; only the low 13 bits of a gain field are used.
 * The register map decodes exact byte offsets, so unaligned addresses are unmapped.
 */
package wb_pkg;

    // one gain register field, upper three bits are stored but unused
    typedef logic [15:0] gain_t;

    localparam int GAIN_USED_WIDTH = 13;

    // 1.0 in Q3.10
    localparam gain_t GAIN_UNITY = 16'h0400;

    // ------------------------------------------------------------
    // AXI4-Lite
    // ------------------------------------------------------------
    typedef logic [4:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // saturated-pixel count of one frame
    typedef logic [23:0] clip_count_t;

    localparam axil_addr_t REG_GAIN_R     = 5'h00;
    localparam axil_addr_t REG_GAIN_G     = 5'h04;
    localparam axil_addr_t REG_GAIN_B     = 5'h08;
    localparam axil_addr_t REG_CLIP_COUNT = 5'h0C;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

/* gain/channel_gain.sv */
/*
 * Per-component gain for R, G and B: multiply, round half up, saturate.
 * Latency is 3 clocks for pixels and strobes; the stream has no stall.
 * Gains are sampled together with the pixel that enters in the same cycle.
 */
`timescale 1ns/1ps

module channel_gain import wb_pkg::*; #(
    parameter int PIXEL_WIDTH         = 8,
    parameter int GAIN_FRACTION_WIDTH = 10
) (
    input  logic                       clk,
    input  logic                       reset_i,

    input  gain_t                      gain_r_i,
    input  gain_t                      gain_g_i,
    input  gain_t                      gain_b_i,

    // R low, G middle, B high
    input  logic [3*PIXEL_WIDTH-1:0]   pix_i,
    input  logic                       de_i,
    input  logic                       hs_i,
    input  logic                       vs_i,

    output logic [3*PIXEL_WIDTH-1:0]   pix_o,
    output logic                       de_o,
    output logic                       hs_o,
    output logic                       vs_o,
    output logic                       clip_o
);

    localparam int PROD_W  = GAIN_USED_WIDTH + PIXEL_WIDTH;
    // one extra bit so the rounding add cannot wrap
    localparam int RND_W   = PROD_W + 1;
    localparam int OVF_BIT = GAIN_FRACTION_WIDTH + PIXEL_WIDTH;
    localparam logic [RND_W-1:0] ROUND_HALF = RND_W'(1) << (GAIN_FRACTION_WIDTH - 1);

    gain_t      gains [3];
    logic [2:0] sat_w;
    logic [2:0] de_sr;
    logic [2:0] hs_sr;
    logic [2:0] vs_sr;

    assign gains[0] = gain_r_i;
    assign gains[1] = gain_g_i;
    assign gains[2] = gain_b_i;

    // ------------------------------------------------------------
    // datapath, one lane per component
    // ------------------------------------------------------------
    for (genvar k = 0; k < 3; k++) begin : g_lane
        logic [PROD_W-1:0]      prod_q;
        logic [RND_W-1:0]       rnd_q;
        logic [PIXEL_WIDTH-1:0] pix_q;

        // anything above the integer field means the result is out of range
        assign sat_w[k] = |rnd_q[RND_W-1:OVF_BIT];

        always_ff @(posedge clk) begin
            prod_q <= PROD_W'(gains[k][GAIN_USED_WIDTH-1:0])
                    * PROD_W'(pix_i[k*PIXEL_WIDTH +: PIXEL_WIDTH]);
            rnd_q  <= RND_W'(prod_q) + ROUND_HALF;
            if (sat_w[k]) begin
                pix_q <= '1;
            end else begin
                pix_q <= rnd_q[GAIN_FRACTION_WIDTH +: PIXEL_WIDTH];
            end
        end

        assign pix_o[k*PIXEL_WIDTH +: PIXEL_WIDTH] = pix_q;
    end

    // ------------------------------------------------------------
    // strobe delay, matched to the three datapath stages
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_sr  <= '0;
            hs_sr  <= '0;
            vs_sr  <= '0;
            clip_o <= 1'b0;
        end else begin
            de_sr  <= {de_sr[1:0], de_i};
            hs_sr  <= {hs_sr[1:0], hs_i};
            vs_sr  <= {vs_sr[1:0], vs_i};
            // flag only pixels that are valid, lines up with de_o
            clip_o <= de_sr[1] & (|sat_w);
        end
    end

    assign de_o = de_sr[2];
    assign hs_o = hs_sr[2];
    assign vs_o = vs_sr[2];

    // an unknown de_o would corrupt the clip statistics downstream
    a_de_known : assert property (
        @(posedge clk) disable iff (reset_i) !$isunknown(de_o)
    );

endmodule

/* hdl/wb_regs.sv */
/*
 * AXI4-Lite slave for the three channel gains and the clip count.
 * Single beat only; a pending response blocks new requests on its own channel.
 * Written gains are pending until the next rising edge of vs, then active.
 * Only exact offsets are mapped, everything else answers SLVERR.
 */
`timescale 1ns/1ps

module wb_regs import wb_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    // write address and data
    input  axil_addr_t  s_axil_awaddr_i,
    input  logic        s_axil_awvalid_i,
    output logic        s_axil_awready_o,
    input  axil_data_t  s_axil_wdata_i,
    input  logic [3:0]  s_axil_wstrb_i,
    input  logic        s_axil_wvalid_i,
    output logic        s_axil_wready_o,

    // write response
    output logic [1:0]  s_axil_bresp_o,
    output logic        s_axil_bvalid_o,
    input  logic        s_axil_bready_i,

    // read address and data
    input  axil_addr_t  s_axil_araddr_i,
    input  logic        s_axil_arvalid_i,
    output logic        s_axil_arready_o,
    output axil_data_t  s_axil_rdata_o,
    output logic [1:0]  s_axil_rresp_o,
    output logic        s_axil_rvalid_o,
    input  logic        s_axil_rready_i,

    input  logic        vs_i,
    input  clip_count_t clip_count_i,

    output gain_t       gain_r_o,
    output gain_t       gain_g_o,
    output gain_t       gain_b_o
);

    gain_t pend_r_q;
    gain_t pend_g_q;
    gain_t pend_b_q;
    logic  wr_accept;
    logic  rd_accept;
    logic  vs_q;

    // byte-wise update, only the two low lanes exist in a gain field
    function automatic gain_t merge_gain(gain_t old, axil_data_t data, logic [3:0] strb);
        gain_t res;
        res = old;
        if (strb[0]) begin
            res[7:0] = data[7:0];
        end
        if (strb[1]) begin
            res[15:8] = data[15:8];
        end
        return res;
    endfunction

    assign wr_accept = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
    assign rd_accept = s_axil_arvalid_i & ~s_axil_rvalid_o;

    assign s_axil_awready_o = wr_accept;
    assign s_axil_wready_o  = wr_accept;
    assign s_axil_arready_o = rd_accept;

    // ------------------------------------------------------------
    // write channel
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_r_q        <= GAIN_UNITY;
            pend_g_q        <= GAIN_UNITY;
            pend_b_q        <= GAIN_UNITY;
            s_axil_bvalid_o <= 1'b0;
        end else begin
            if (s_axil_bvalid_o && s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
            if (wr_accept) begin
                s_axil_bvalid_o <= 1'b1;
                case (s_axil_awaddr_i)
                    REG_GAIN_R: pend_r_q <= merge_gain(pend_r_q, s_axil_wdata_i, s_axil_wstrb_i);
                    REG_GAIN_G: pend_g_q <= merge_gain(pend_g_q, s_axil_wdata_i, s_axil_wstrb_i);
                    REG_GAIN_B: pend_b_q <= merge_gain(pend_b_q, s_axil_wdata_i, s_axil_wstrb_i);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            case (s_axil_awaddr_i)
                REG_GAIN_R, REG_GAIN_G, REG_GAIN_B: s_axil_bresp_o <= AXI_RESP_OKAY;
                default:                            s_axil_bresp_o <= AXI_RESP_SLVERR;
            endcase
        end
    end

    // ------------------------------------------------------------
    // read channel
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

    // readback shows the pending gains, not the active ones
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_axil_rresp_o <= AXI_RESP_OKAY;
            case (s_axil_araddr_i)
                REG_GAIN_R:     s_axil_rdata_o <= axil_data_t'(pend_r_q);
                REG_GAIN_G:     s_axil_rdata_o <= axil_data_t'(pend_g_q);
                REG_GAIN_B:     s_axil_rdata_o <= axil_data_t'(pend_b_q);
                REG_CLIP_COUNT: s_axil_rdata_o <= axil_data_t'(clip_count_i);
                default: begin
                    s_axil_rdata_o <= '0;
                    s_axil_rresp_o <= AXI_RESP_SLVERR;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // frame-start transfer of pending to active gains
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vs_q     <= 1'b0;
            gain_r_o <= GAIN_UNITY;
            gain_g_o <= GAIN_UNITY;
            gain_b_o <= GAIN_UNITY;
        end else begin
            vs_q <= vs_i;
            if (vs_i && !vs_q) begin
                gain_r_o <= pend_r_q;
                gain_g_o <= pend_g_q;
                gain_b_o <= pend_b_q;
            end
        end
    end

    a_bvalid_hold : assert property (
        @(posedge clk) disable iff (reset_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o
    );

    a_rdata_stable : assert property (
        @(posedge clk) disable iff (reset_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> $stable(s_axil_rdata_o)
    );

endmodule

/* hdl/clip_stats.sv */
/*
 * Counts saturated valid pixels in one frame.
 * The total of the last complete frame is latched at each rising edge of vs.
 * The count saturates at all ones instead of wrapping.
 */
`timescale 1ns/1ps

module clip_stats import wb_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,

    input  logic        de_i,
    input  logic        vs_i,
    input  logic        clip_i,

    output clip_count_t clip_count_o
);

    clip_count_t cnt_q;
    logic        vs_q;
    logic        vs_rise;
    logic        hit;

    assign vs_rise = vs_i & ~vs_q;
    assign hit     = de_i & clip_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vs_q         <= 1'b0;
            cnt_q        <= '0;
            clip_count_o <= '0;
        end else begin
            vs_q <= vs_i;
            if (vs_rise) begin
                clip_count_o <= cnt_q;
                // a clipped pixel on the edge cycle belongs to the new frame
                cnt_q        <= hit ? clip_count_t'(1) : '0;
            end else if (hit && cnt_q != '1) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    a_cnt_monotonic : assert property (
        @(posedge clk) disable iff (reset_i)
        !vs_rise |=> cnt_q >= $past(cnt_q)
    );

endmodule

/* hdl/white_balance_top.sv */
/*
 * White-balance stage: per-channel gain on a parallel RGB stream.
 * Video latency is 3 clocks; the stream has no back-pressure.
 * New gains apply from the next rising edge of vs_i.
 */
`timescale 1ns/1ps

module white_balance_top import wb_pkg::*; #(
    // legal 1 to 13
    parameter int PIXEL_WIDTH         = 8,
    // legal 1 to 12
    parameter int GAIN_FRACTION_WIDTH = 10
) (
    input  logic                     clk,
    input  logic                     reset_i,

    // video in, R low, G middle, B high
    input  logic [3*PIXEL_WIDTH-1:0] pix_i,
    input  logic                     de_i,
    input  logic                     hs_i,
    input  logic                     vs_i,

    // video out
    output logic [3*PIXEL_WIDTH-1:0] pix_o,
    output logic                     de_o,
    output logic                     hs_o,
    output logic                     vs_o,

    // AXI4-Lite slave
    input  axil_addr_t               s_axil_awaddr_i,
    input  logic                     s_axil_awvalid_i,
    output logic                     s_axil_awready_o,
    input  axil_data_t               s_axil_wdata_i,
    input  logic [3:0]               s_axil_wstrb_i,
    input  logic                     s_axil_wvalid_i,
    output logic                     s_axil_wready_o,
    output logic [1:0]               s_axil_bresp_o,
    output logic                     s_axil_bvalid_o,
    input  logic                     s_axil_bready_i,
    input  axil_addr_t               s_axil_araddr_i,
    input  logic                     s_axil_arvalid_i,
    output logic                     s_axil_arready_o,
    output axil_data_t               s_axil_rdata_o,
    output logic [1:0]               s_axil_rresp_o,
    output logic                     s_axil_rvalid_o,
    input  logic                     s_axil_rready_i
);

    gain_t       gain_r;
    gain_t       gain_g;
    gain_t       gain_b;
    logic        clip;
    clip_count_t clip_count;

    initial begin
        assert (PIXEL_WIDTH >= 1 && PIXEL_WIDTH <= 13)
            else $fatal(1, "PIXEL_WIDTH out of range");
        assert (GAIN_FRACTION_WIDTH >= 1 && GAIN_FRACTION_WIDTH <= 12)
            else $fatal(1, "GAIN_FRACTION_WIDTH out of range");
    end

    // register slave sees the input vs, so the swap leads the pixels
    wb_regs i_wb_regs (
        .clk              (clk),
        .reset_i          (reset_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .vs_i             (vs_i),
        .clip_count_i     (clip_count),
        .gain_r_o         (gain_r),
        .gain_g_o         (gain_g),
        .gain_b_o         (gain_b)
    );

    channel_gain #(
        .PIXEL_WIDTH         (PIXEL_WIDTH),
        .GAIN_FRACTION_WIDTH (GAIN_FRACTION_WIDTH)
    ) i_channel_gain (
        .clk      (clk),
        .reset_i  (reset_i),
        .gain_r_i (gain_r),
        .gain_g_i (gain_g),
        .gain_b_i (gain_b),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .pix_o    (pix_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o),
        .clip_o   (clip)
    );

    // statistics follow the output timing, frame edges come from vs_o
    clip_stats i_clip_stats (
        .clk          (clk),
        .reset_i      (reset_i),
        .de_i         (de_o),
        .vs_i         (vs_o),
        .clip_i       (clip),
        .clip_count_o (clip_count)
    );

endmodule

/* dv/wb_ref_model.svh */
/*
 * Reference model of the gain stage, included inside the testbench module.
 * Expects PW and FW to be declared before the include and gain_t from wb_pkg.
 * Only the low 13 bits of a gain count, as in the register map.
 */
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

// component times gain, rounded half up, before saturation
function automatic longint unsigned rounded_product(logic [PW-1:0] comp, gain_t gain);
    longint unsigned prod;
    prod = 64'(comp) * 64'(gain[GAIN_USED_WIDTH-1:0]);
    return (prod + (64'd1 << (FW - 1))) >> FW;
endfunction

function automatic bit component_clips(logic [PW-1:0] comp, gain_t gain);
    return rounded_product(comp, gain) > ((64'd1 << PW) - 1);
endfunction

function automatic logic [PW-1:0] gained_component(logic [PW-1:0] comp, gain_t gain);
    if (component_clips(comp, gain)) begin
        return '1;
    end
    return PW'(rounded_product(comp, gain));
endfunction

// R in the low field, B in the high field
function automatic logic [3*PW-1:0] gained_pixel(logic [3*PW-1:0] pix, gain_t gains [3]);
    logic [3*PW-1:0] res;
    for (int k = 0; k < 3; k++) begin
        res[k*PW +: PW] = gained_component(pix[k*PW +: PW], gains[k]);
    end
    return res;
endfunction

function automatic bit pixel_clips(logic [3*PW-1:0] pix, gain_t gains [3]);
    bit any_clip;
    any_clip = 1'b0;
    for (int k = 0; k < 3; k++) begin
        any_clip |= component_clips(pix[k*PW +: PW], gains[k]);
    end
    return any_clip;
endfunction

`endif

/* dv/tb_white_balance.sv */
/*
 * Testbench for the white-balance stage at default parameters.
 * Random frames and AXI4-Lite traffic from a fixed seed, checked against a model.
 * Inputs change on the falling edge, outputs are sampled while the clock is low.
 */
`timescale 1ns/1ps

module tb_white_balance import wb_pkg::*; ();

    localparam int PW    = 8;
    localparam int FW    = 10;
    localparam int PIX_W = 3 * PW;

    // frame geometry in clock cycles
    localparam int NUM_FRAMES    = 9;
    localparam int ROWS          = 6;
    localparam int ROW_LEN       = 24;
    localparam int HS_LEN        = 2;
    localparam int HBLANK        = 4;
    localparam int VS_LEN        = 3;
    localparam int VBLANK        = 12;
    localparam int FRAME_CYCLES  = VS_LEN + ROWS * (HS_LEN + ROW_LEN + HBLANK) + VBLANK;
    // register traffic per frame stays well below this
    localparam int AXI_CYCLES     = 200;
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES + 1) * (FRAME_CYCLES + AXI_CYCLES) + 500;
    localparam int REGTEST_FRAME  = 7;

    localparam axil_addr_t GAIN_REGS [3] = '{REG_GAIN_R, REG_GAIN_G, REG_GAIN_B};

    logic             clk, reset_i;
    logic [PIX_W-1:0] pix_i, pix_o;
    logic             de_i, hs_i, vs_i, de_o, hs_o, vs_o;
    axil_addr_t       s_axil_awaddr_i, s_axil_araddr_i;
    axil_data_t       s_axil_wdata_i, s_axil_rdata_o;
    logic [3:0]       s_axil_wstrb_i;
    logic [1:0]       s_axil_bresp_o, s_axil_rresp_o;
    logic             s_axil_awvalid_i, s_axil_wvalid_i, s_axil_bready_i;
    logic             s_axil_arvalid_i, s_axil_rready_i;
    logic             s_axil_awready_o, s_axil_wready_o, s_axil_bvalid_o;
    logic             s_axil_arready_o, s_axil_rvalid_o;

    // model state
    gain_t            pend_gain [3];
    gain_t            act_gain [3];
    logic [PIX_W-1:0] expected_q [$];
    logic [8:0]       strobe_hist;
    int               cur_frame_clips, prev_frame_clips;
    int               pixels_sent, pixels_checked, cycle_count;
    int unsigned      seed_ret;

    `include "wb_ref_model.svh"

    white_balance_top #(.PIXEL_WIDTH(PW), .GAIN_FRACTION_WIDTH(FW)) i_white_balance_top (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------
    task automatic axil_write(axil_addr_t addr, axil_data_t data, logic [3:0] strb,
                              int delay, output logic [1:0] resp);
        @(negedge clk);
        s_axil_awaddr_i  = addr;
        s_axil_wdata_i   = data;
        s_axil_wstrb_i   = strb;
        s_axil_awvalid_i = 1'b1;
        s_axil_wvalid_i  = 1'b1;
        // ready follows the valids within the cycle, look once they have settled
        #1;
        check_equal(32'(s_axil_awready_o), 32'd1, "awready with both valids and no response");
        check_equal(32'(s_axil_wready_o), 32'd1, "wready with both valids and no response");
        do @(negedge clk); while (!s_axil_bvalid_o);
        check_equal(32'({s_axil_awready_o, s_axil_wready_o}), 32'd0,
                    "awready and wready low while bvalid pending");
        s_axil_awvalid_i = 1'b0;
        s_axil_wvalid_i  = 1'b0;
        resp = s_axil_bresp_o;
        repeat (delay) begin
            @(negedge clk);
            check_equal(32'(s_axil_bvalid_o), 32'd1, "bvalid held while bready low");
            check_equal(32'(s_axil_bresp_o), 32'(resp), "bresp stable while bready low");
        end
        s_axil_bready_i = 1'b1;
        @(negedge clk);
        check_equal(32'(s_axil_bvalid_o), 32'd0, "bvalid cleared after bready");
        s_axil_bready_i = 1'b0;
    endtask

    task automatic read_check(axil_addr_t addr, axil_data_t exp_data, logic [1:0] exp_resp,
                              int delay);
        axil_data_t data;
        @(negedge clk);
        s_axil_araddr_i  = addr;
        s_axil_arvalid_i = 1'b1;
        #1;
        check_equal(32'(s_axil_arready_o), 32'd1, "arready with no read response pending");
        do @(negedge clk); while (!s_axil_rvalid_o);
        check_equal(32'(s_axil_arready_o), 32'd0, "arready low while rvalid pending");
        s_axil_arvalid_i = 1'b0;
        data = s_axil_rdata_o;
        check_equal(data, exp_data, $sformatf("read data at 0x%02h", addr));
        check_equal(32'(s_axil_rresp_o), 32'(exp_resp), $sformatf("rresp at 0x%02h", addr));
        repeat (delay) begin
            @(negedge clk);
            check_equal(32'(s_axil_rvalid_o), 32'd1, "rvalid held while rready low");
            check_equal(s_axil_rdata_o, data, "rdata stable while rready low");
        end
        s_axil_rready_i = 1'b1;
        @(negedge clk);
        check_equal(32'(s_axil_rvalid_o), 32'd0, "rvalid cleared after rready");
        s_axil_rready_i = 1'b0;
    endtask

    // only the gain offsets are writable, per byte lane 0 and 1
    task automatic write_reg(axil_addr_t addr, axil_data_t data, logic [3:0] strb, int delay);
        logic [1:0] resp;
        logic [1:0] exp_resp;
        exp_resp = AXI_RESP_SLVERR;
        axil_write(addr, data, strb, delay, resp);
        for (int k = 0; k < 3; k++) begin
            if (addr == GAIN_REGS[k]) begin
                exp_resp = AXI_RESP_OKAY;
                if (strb[0]) pend_gain[k][7:0] = data[7:0];
                if (strb[1]) pend_gain[k][15:8] = data[15:8];
            end
        end
        check_equal(32'(resp), 32'(exp_resp), $sformatf("write response at 0x%02h", addr));
    endtask

    task automatic write_random_gains();
        for (int k = 0; k < 3; k++) begin
            write_reg(GAIN_REGS[k], axil_data_t'($urandom_range(16'h1FFF)), 4'hF,
                      int'($urandom_range(3)));
        end
        for (int k = 0; k < 3; k++) begin
            read_check(GAIN_REGS[k], axil_data_t'(pend_gain[k]), AXI_RESP_OKAY,
                       int'($urandom_range(3)));
        end
    endtask

    task automatic register_tests();
        write_reg(REG_GAIN_R, 32'h0000_1234, 4'hF, 0);
        write_reg(REG_GAIN_R, 32'hFFFF_AB56, 4'b0001, 2);
        write_reg(REG_GAIN_G, 32'h0000_0A77, 4'b0010, 0);
        write_reg(REG_GAIN_B, 32'hFFFF_0300, 4'hF, 1);
        // upper lanes hold nothing of a gain
        write_reg(REG_GAIN_B, 32'hDEAD_0C80, 4'b1100, 4);
        read_check(REG_GAIN_R, 32'h0000_1256, AXI_RESP_OKAY, 3);
        read_check(REG_GAIN_G, axil_data_t'(pend_gain[1]), AXI_RESP_OKAY, 0);
        read_check(REG_GAIN_B, 32'h0000_0300, AXI_RESP_OKAY, 5);
        write_reg(REG_CLIP_COUNT, 32'h0000_00FF, 4'hF, 0);
        write_reg(5'h10, 32'h0000_0800, 4'hF, 3);
        write_reg(5'h02, 32'h0000_0800, 4'hF, 0);
        read_check(5'h10, '0, AXI_RESP_SLVERR, 4);
        read_check(5'h1C, '0, AXI_RESP_SLVERR, 0);
        read_check(5'h06, '0, AXI_RESP_SLVERR, 2);
        for (int k = 0; k < 3; k++) begin
            read_check(GAIN_REGS[k], axil_data_t'(pend_gain[k]), AXI_RESP_OKAY, 0);
        end
    endtask

    // ------------------------------------------------------------
    // video stimulus
    // ------------------------------------------------------------
    task automatic drive_video(logic [PIX_W-1:0] pix, logic de, logic hs, logic vs);
        @(negedge clk);
        pix_i = pix;
        de_i  = de;
        hs_i  = hs;
        vs_i  = vs;
        if (de) begin
            expected_q.push_back(gained_pixel(pix, act_gain));
            pixels_sent++;
            if (pixel_clips(pix, act_gain)) cur_frame_clips++;
        end
    endtask

    task automatic drive_frame(int rows);
        // pending gains become active at the frame start
        act_gain         = pend_gain;
        prev_frame_clips = cur_frame_clips;
        cur_frame_clips  = 0;
        repeat (VS_LEN) drive_video(PIX_W'($urandom()), 1'b0, 1'b0, 1'b1);
        repeat (rows) begin
            repeat (HS_LEN) drive_video(PIX_W'($urandom()), 1'b0, 1'b1, 1'b0);
            repeat (ROW_LEN) drive_video(PIX_W'($urandom()), $urandom_range(7) != 0, 1'b0, 1'b0);
            repeat (HBLANK) drive_video(PIX_W'($urandom()), 1'b0, 1'b0, 1'b0);
        end
        repeat (VBLANK) drive_video('0, 1'b0, 1'b0, 1'b0);
    endtask

    // clip count read after vs_o, optional gain write in mid-frame
    task automatic frame_side_traffic(int frame_idx);
        do @(negedge clk); while (!vs_o);
        @(negedge clk);
        read_check(REG_CLIP_COUNT, axil_data_t'(prev_frame_clips), AXI_RESP_OKAY,
                   int'($urandom_range(2)));
        if (frame_idx % 3 == 2) begin
            write_random_gains();
        end
    endtask

    // ------------------------------------------------------------
    // output checks, strobes trail the inputs by 3 clocks
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (reset_i) begin
            strobe_hist <= '0;
        end else begin
            strobe_hist <= {strobe_hist[5:0], de_i, hs_i, vs_i};
        end
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d clock cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (!reset_i) begin
            check_equal(32'({de_o, hs_o, vs_o}), 32'(strobe_hist[8:6]), "de, hs, vs at output");
            if (de_o && expected_q.size() == 0) begin
                $display("pixel came out at %0t with no pixel expected", $time);
                abort_run();
            end else if (de_o) begin
                check_equal(32'(pix_o), 32'(expected_q.pop_front()), "output pixel");
                pixels_checked++;
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset_i = 1'b1;
        drive_idle: begin
            pix_i = '0;
            de_i = 1'b0;
            hs_i = 1'b0;
            vs_i = 1'b0;
        end
        s_axil_awaddr_i = '0;
        s_axil_awvalid_i = 1'b0;
        s_axil_wdata_i = '0;
        s_axil_wstrb_i = '0;
        s_axil_wvalid_i = 1'b0;
        s_axil_bready_i = 1'b0;
        s_axil_araddr_i = '0;
        s_axil_arvalid_i = 1'b0;
        s_axil_rready_i = 1'b0;
        cycle_count = 0;
        cur_frame_clips = 0;
        prev_frame_clips = 0;
        pixels_sent = 0;
        pixels_checked = 0;
        seed_ret = $urandom(32'hc438_e4cc);
        pend_gain = '{GAIN_UNITY, GAIN_UNITY, GAIN_UNITY};
        act_gain = pend_gain;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;

        for (int k = 0; k < 3; k++) begin
            read_check(GAIN_REGS[k], axil_data_t'(GAIN_UNITY), AXI_RESP_OKAY, 0);
        end
        // frame 0 at unity, frames after a mid-frame write keep those gains
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f == REGTEST_FRAME) begin
                register_tests();
            end else if (f > 0 && (f - 1) % 3 != 2) begin
                write_random_gains();
            end
            fork
                drive_frame(ROWS);
                frame_side_traffic(f);
            join
        end
        // closing vs latches the count of the last frame, its blanking drains the pipeline
        fork
            drive_frame(0);
            frame_side_traffic(NUM_FRAMES);
        join

        if (pixels_checked != pixels_sent || pixels_sent == 0) begin
            $display("%0d pixels sent but %0d pixels checked", pixels_sent, pixels_checked);
            abort_run();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+dv
common/wb_pkg.sv
gain/channel_gain.sv
hdl/wb_regs.sv
hdl/clip_stats.sv
hdl/white_balance_top.sv
dv/tb_white_balance.sv

/* Makefile */
# Verilator build and run of the white-balance testbench.
# Any variable below can be overridden on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_white_balance
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
